// ==== lsu_consts.svh ====
// Width and limit macros for the load/store unit
// The split logic assumes 32-bit data with four byte lanes
// The response queue in the bus master holds exactly two entries, so the
// outstanding limit must not be raised above two
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Byte address width on the instruction side and on the bus
`define LSU_ADDR_W 32

// Data word width, four byte lanes
`define LSU_DATA_W 32

// Granted bus transfers that may wait for a response at the same time
`define LSU_MAX_OUTSTANDING 2

`endif

// ==== lsu_obi_master.sv ====
// OBI-style bus master for the load/store unit
// Responses must come in order, one per grant, at least one cycle after it
// The response queue has two entries and matches the outstanding limit
// Loads are zero-extended and stores return a zero result
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_obi_master
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  lsu_xfer_if.dst                xfer_i,
  output logic                   obi_req_o,
  input  logic                   obi_gnt_i,
  output logic [`LSU_ADDR_W-1:0] obi_addr_o,
  output logic                   obi_we_o,
  output logic [3:0]             obi_be_o,
  output logic [`LSU_DATA_W-1:0] obi_wdata_o,
  input  logic                   obi_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] obi_rdata_i,
  output logic                   lsu_rvalid_o,
  output logic [`LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                   pending_o
);

  localparam logic [1:0] MAX_OUT = 2'(`LSU_MAX_OUTSTANDING);

  logic [1:0]               cnt_q;
  logic                     issue;
  lsu_addr_u                req_addr;

  // Response metadata queue
  logic                     q_we [2];
  logic [1:0]               q_offset [2];
  logic [1:0]               q_size [2];
  logic                     q_split [2];
  logic                     q_last [2];
  logic                     wr_ptr_q;
  logic                     rd_ptr_q;

  // Result path
  logic [`LSU_DATA_W-1:0]   first_q;
  logic [`LSU_DATA_W-1:0]   merged;
  logic [2*`LSU_DATA_W-1:0] rot_dbl;
  logic [`LSU_DATA_W-1:0]   size_mask;
  logic                     rvalid_q;
  logic [`LSU_DATA_W-1:0]   rdata_q;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  // No request is raised once the limit is reached
  assign obi_req_o    = xfer_i.valid && (cnt_q < MAX_OUT);
  assign xfer_i.ready = obi_gnt_i && (cnt_q < MAX_OUT);
  assign issue        = obi_req_o && obi_gnt_i;

  // Bus addresses are always word aligned
  assign req_addr.part.word   = xfer_i.word_addr;
  assign req_addr.part.offset = 2'b00;

  assign obi_addr_o  = req_addr.addr;
  assign obi_we_o    = xfer_i.we;
  assign obi_be_o    = xfer_i.be;
  assign obi_wdata_o = xfer_i.wdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else if (issue && !obi_rvalid_i) begin
      cnt_q <= cnt_q + 2'd1;
    end else if (!issue && obi_rvalid_i) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  //////////////////////////////////////////////////
  // Response metadata queue
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (issue) begin
      q_we[wr_ptr_q]     <= xfer_i.we;
      q_offset[wr_ptr_q] <= xfer_i.offset;
      q_size[wr_ptr_q]   <= xfer_i.size;
      q_split[wr_ptr_q]  <= xfer_i.split;
      q_last[wr_ptr_q]   <= xfer_i.last;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (issue) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (obi_rvalid_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  //////////////////////////////////////////////////
  // Load result
  //////////////////////////////////////////////////

  // The first read word of a split load waits here for the second one
  always_ff @(posedge clk) begin
    if (obi_rvalid_i && !q_last[rd_ptr_q]) begin
      first_q <= obi_rdata_i;
    end
  end

  // In a split load the first part owns the lanes from the offset upwards
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (q_split[rd_ptr_q] && (2'(i) >= q_offset[rd_ptr_q])) begin
        merged[8*i +: 8] = first_q[8*i +: 8];
      end else begin
        merged[8*i +: 8] = obi_rdata_i[8*i +: 8];
      end
    end
  end

  // Rotate right by the offset to bring the first byte to lane 0
  assign rot_dbl = {merged, merged} >> {q_offset[rd_ptr_q], 3'b000};

  always_comb begin
    case (q_size[rd_ptr_q])
      2'd0:    size_mask = 32'h0000_00ff;
      2'd1:    size_mask = 32'h0000_ffff;
      default: size_mask = 32'hffff_ffff;
    endcase
  end

  // One result pulse per instruction, on the response of its last part
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= obi_rvalid_i && q_last[rd_ptr_q];
      if (obi_rvalid_i && q_last[rd_ptr_q]) begin
        rdata_q <= q_we[rd_ptr_q] ? '0 : (rot_dbl[`LSU_DATA_W-1:0] & size_mask);
      end
    end
  end

  assign lsu_rvalid_o = rvalid_q;
  assign lsu_rdata_o  = rdata_q;

  // The result cycle still counts as work in flight
  assign pending_o = (cnt_q != 2'd0) || rvalid_q;

endmodule

// ==== lsu_pkg.sv ====
// Shared types for the load/store unit
// Addresses are byte addresses and a word holds four bytes
`include "lsu_consts.svh"

package lsu_pkg;

  // One address word, read either as a flat byte address or as a word index
  // plus the byte offset inside that word
  typedef union packed {
    logic [`LSU_ADDR_W-1:0] addr;
    struct packed {
      // Index of the aligned word
      logic [`LSU_ADDR_W-3:0] word;
      // Byte lane of the first accessed byte
      logic [1:0]             offset;
    } part;
  } lsu_addr_u;

endpackage

// ==== lsu_properties.sv ====
// Bus master checks, bound into every lsu_obi_master instance
// The split address check assumes one instruction's parts are issued back to back
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   req_i,
  input logic                   gnt_i,
  input logic [`LSU_ADDR_W-1:0] addr_i,
  input logic                   rvalid_i,
  input logic                   pending_i,
  input logic [1:0]             cnt_i,
  input logic                   split_i,
  input logic                   last_i
);

  logic                   issue;
  logic [1:0]             own_cnt_q;
  logic [`LSU_ADDR_W-3:0] first_word_q;

  assign issue = req_i && gnt_i;

  // Outstanding transfers as seen from the bus alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      own_cnt_q <= 2'd0;
    end else if (issue && !rvalid_i) begin
      own_cnt_q <= own_cnt_q + 2'd1;
    end else if (!issue && rvalid_i) begin
      own_cnt_q <= own_cnt_q - 2'd1;
    end
  end

  // Word of the first part of a split access
  always_ff @(posedge clk) begin
    if (issue && split_i && !last_i) begin
      first_word_q <= addr_i[`LSU_ADDR_W-1:2];
    end
  end

  cnt_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= `LSU_MAX_OUTSTANDING)
    else $error("Outstanding count above the limit");

  no_orphan_response: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> own_cnt_q != 2'd0)
    else $error("Response without an outstanding request");

  busy_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
    own_cnt_q != 2'd0 |-> pending_i)
    else $error("Master not pending with transfers outstanding");

  split_next_word: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && split_i && last_i) |->
      addr_i[`LSU_ADDR_W-1:2] == (`LSU_ADDR_W-2)'(first_word_q + 1'b1))
    else $error("Second part of a split access is not on the next word");

  addr_held: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
    else $error("Request address changed before its grant");

endmodule

bind lsu_obi_master lsu_properties props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_i     (obi_req_o),
  .gnt_i     (obi_gnt_i),
  .addr_i    (obi_addr_o),
  .rvalid_i  (obi_rvalid_i),
  .pending_i (pending_o),
  .cnt_i     (cnt_q),
  .split_i   (xfer_i.split),
  .last_i    (xfer_i.last)
);

// ==== lsu_split_unit.sv ====
// Split unit: takes one load or store and emits one or two aligned transfers
// Size encoding is 0 byte, 1 half, 2 word, and 3 is treated as a word
// A new instruction is only accepted while the unit is idle
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_split_unit
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   lsu_valid_i,
  output logic                   lsu_ready_o,
  input  logic                   lsu_we_i,
  input  logic [1:0]             lsu_size_i,
  input  logic [`LSU_ADDR_W-1:0] lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  output logic                   busy_o,
  lsu_xfer_if.src                xfer_o
);

  // FSM encoding
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_FIRST  = 2'd1;
  localparam logic [1:0] ST_SECOND = 2'd2;

  logic [1:0]               state_q;
  logic [1:0]               state_d;
  logic                     accept;

  // Registered instruction
  lsu_addr_u                addr_q;
  logic                     we_q;
  logic [1:0]               size_q;
  logic [`LSU_DATA_W-1:0]   wdata_q;

  // Decoded access
  logic [3:0]               be_base;
  logic [7:0]               be_wide;
  logic                     is_split;
  logic [2*`LSU_DATA_W-1:0] wdata_dbl;

  //////////////////////////////////////////////////
  // Instruction capture
  //////////////////////////////////////////////////

  assign lsu_ready_o = (state_q == ST_IDLE);
  assign accept      = lsu_valid_i && lsu_ready_o;
  assign busy_o      = (state_q != ST_IDLE);

  // Copy of the accepted instruction, held until its last part has left
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q.addr <= lsu_addr_i;
      we_q        <= lsu_we_i;
      size_q      <= lsu_size_i;
      wdata_q     <= lsu_wdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Byte enables, split decision, write data
  //////////////////////////////////////////////////

  always_comb begin
    case (size_q)
      2'd0:    be_base = 4'b0001;
      2'd1:    be_base = 4'b0011;
      default: be_base = 4'b1111;
    endcase
  end

  // Lanes 3..0 belong to the addressed word, lanes 7..4 spill into the next one
  assign be_wide  = {4'b0000, be_base} << addr_q.part.offset;
  assign is_split = |be_wide[7:4];

  // Rotate left by the byte offset so each byte lands on its own lane
  assign wdata_dbl = {wdata_q, wdata_q} << {addr_q.part.offset, 3'b000};

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (lsu_valid_i) begin
          state_d = ST_FIRST;
        end
      end
      ST_FIRST: begin
        // A split access goes on to the next word
        if (xfer_o.ready) begin
          state_d = is_split ? ST_SECOND : ST_IDLE;
        end
      end
      ST_SECOND: begin
        if (xfer_o.ready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Both parts of a split access carry the same data and metadata
  assign xfer_o.valid     = (state_q != ST_IDLE);
  assign xfer_o.word_addr = (state_q == ST_SECOND) ? addr_q.part.word + 1'b1
                                                   : addr_q.part.word;
  assign xfer_o.be        = (state_q == ST_SECOND) ? be_wide[7:4] : be_wide[3:0];
  assign xfer_o.we        = we_q;
  assign xfer_o.wdata     = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];
  assign xfer_o.offset    = addr_q.part.offset;
  assign xfer_o.size      = size_q;
  assign xfer_o.split     = is_split;
  assign xfer_o.last      = !is_split || (state_q == ST_SECOND);

endmodule

// ==== lsu_tb.sv ====
// Directed testbench for the load/store unit
// Only the low 8 address bits reach the 256-byte memory model, so addresses wrap
// One instruction is in flight at a time, and each waits for its result pulse
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb;

  localparam int DRIVE_DELAY    = 1;
  localparam int TIMEOUT_CYCLES = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   lsu_valid;
  logic                   lsu_ready;
  logic                   lsu_we;
  logic [1:0]             lsu_size;
  logic [`LSU_ADDR_W-1:0] lsu_addr;
  logic [`LSU_DATA_W-1:0] lsu_wdata;
  logic                   lsu_rvalid;
  logic [`LSU_DATA_W-1:0] lsu_rdata;
  logic                   lsu_busy;
  logic                   obi_req;
  logic                   obi_gnt;
  logic [`LSU_ADDR_W-1:0] obi_addr;
  logic                   obi_we;
  logic [3:0]             obi_be;
  logic [`LSU_DATA_W-1:0] obi_wdata;
  logic                   obi_rvalid;
  logic [`LSU_DATA_W-1:0] obi_rdata;

  // Memory seen by the bus, and the expected memory kept by the tests
  logic [7:0]             bus_mem [256];
  logic [7:0]             ref_mem [256];
  // Read words waiting for their response, oldest first
  logic [31:0]            rsp_queue [$];
  // Granted transfers of the current instruction
  logic [31:0]            log_addr [$];
  logic [3:0]             log_be [$];
  logic                   log_we [$];
  bit                     random_delays;
  integer                 seed = 73;

  tb_clock_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_valid_i  (lsu_valid),
    .lsu_ready_o  (lsu_ready),
    .lsu_we_i     (lsu_we),
    .lsu_size_i   (lsu_size),
    .lsu_addr_i   (lsu_addr),
    .lsu_wdata_i  (lsu_wdata),
    .lsu_rvalid_o (lsu_rvalid),
    .lsu_rdata_o  (lsu_rdata),
    .lsu_busy_o   (lsu_busy),
    .obi_req_o    (obi_req),
    .obi_gnt_i    (obi_gnt),
    .obi_addr_o   (obi_addr),
    .obi_we_o     (obi_we),
    .obi_be_o     (obi_be),
    .obi_wdata_o  (obi_wdata),
    .obi_rvalid_i (obi_rvalid),
    .obi_rdata_i  (obi_rdata)
  );

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Initial memory byte, every address bit changes the value
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + 11);
  endfunction

  //////////////////////////////////////////////////
  // Bus responder
  //////////////////////////////////////////////////

  // Called between edges for a transfer that is granted at the next edge
  task automatic serve_grant();
    logic [31:0] rd_word;
    logic [5:0]  widx;
    widx = obi_addr[7:2];
    for (int l = 0; l < 4; l++) begin
      rd_word[8*l +: 8] = bus_mem[{widx, 2'(l)}];
    end
    rsp_queue.push_back(rd_word);
    // Stores only touch the enabled lanes
    for (int l = 0; l < 4; l++) begin
      if (obi_we && obi_be[l]) begin
        bus_mem[{widx, 2'(l)}] = obi_wdata[8*l +: 8];
      end
    end
    log_addr.push_back(obi_addr);
    log_be.push_back(obi_be);
    log_we.push_back(obi_we);
  endtask

  initial begin : bus_responder
    bit gnt_fire;
    bit rsp_fire;
    obi_gnt    = 1'b0;
    obi_rvalid = 1'b0;
    obi_rdata  = '0;
    for (int a = 0; a < 256; a++) begin
      bus_mem[a] = fill_byte(a);
    end
    forever begin
      // Handshakes are judged on stable values, half a cycle before the edge
      @(negedge clk);
      gnt_fire = obi_req && obi_gnt;
      rsp_fire = obi_rvalid;
      if (gnt_fire) begin
        serve_grant();
      end
      @(posedge clk);
      #DRIVE_DELAY;
      if (rsp_fire) begin
        void'(rsp_queue.pop_front());
      end
      // A response goes out at the earliest one cycle after its grant
      obi_rvalid = (rsp_queue.size() > 0) && (!random_delays || ($random(seed) & 1));
      obi_rdata  = obi_rvalid ? rsp_queue[0] : '0;
      obi_gnt    = !random_delays || (($random(seed) & 3) != 0);
    end
  end

  //////////////////////////////////////////////////
  // Instruction driver
  //////////////////////////////////////////////////

  task automatic await_reset();
    int cycles;
    cycles = 0;
    while (!rst_n) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_run("Reset was never released");
      end
    end
  endtask

  // Issues one access, waits for its result and checks data and bus transfers
  task automatic do_access(input logic we, input logic [1:0] size,
                           input logic [31:0] addr, input logic [31:0] wdata);
    int          nbytes;
    int          lane;
    int          cycles;
    int          exp_xfers;
    bit          seen;
    logic [7:0]  be_lanes;
    logic [31:0] exp_rdata;
    logic [31:0] got_rdata;
    nbytes    = 1 << size;
    exp_rdata = '0;
    be_lanes  = '0;
    // Bytes past lane 3 belong to the next word
    for (int i = 0; i < nbytes; i++) begin
      lane                = addr[1:0] + i;
      be_lanes[lane]      = 1'b1;
      exp_rdata[8*i +: 8] = ref_mem[8'(addr + i)];
      if (we) begin
        ref_mem[8'(addr + i)] = wdata[8*i +: 8];
      end
    end
    if (we) begin
      exp_rdata = '0;
    end
    exp_xfers = (be_lanes[7:4] != 4'b0000) ? 2 : 1;
    log_addr.delete();
    log_be.delete();
    log_we.delete();

    @(posedge clk);
    #DRIVE_DELAY;
    lsu_valid = 1'b1;
    lsu_we    = we;
    lsu_size  = size;
    lsu_addr  = addr;
    lsu_wdata = wdata;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = lsu_ready;
      cycles++;
      if (!seen && cycles > TIMEOUT_CYCLES) begin
        fail_run("Instruction was not accepted in time");
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    lsu_valid = 1'b0;

    // Busy holds from acceptance up to and including the result pulse
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk);
      compare_value("lsu_busy_o", lsu_busy, 1'b1);
      seen      = lsu_rvalid;
      got_rdata = lsu_rdata;
      cycles++;
      if (!seen && cycles > TIMEOUT_CYCLES) begin
        fail_run("No result pulse arrived in time");
      end
    end
    compare_value("lsu_rdata_o", got_rdata, exp_rdata);
    @(negedge clk);
    compare_value("lsu_rvalid_o", lsu_rvalid, 1'b0);
    compare_value("lsu_busy_o", lsu_busy, 1'b0);

    compare_value("transfer count", log_addr.size(), exp_xfers);
    compare_value("obi_addr_o", log_addr[0], {addr[31:2], 2'b00});
    compare_value("obi_be_o", log_be[0], be_lanes[3:0]);
    compare_value("obi_we_o", log_we[0], we);
    if (exp_xfers == 2) begin
      compare_value("obi_addr_o", log_addr[1], {addr[31:2], 2'b00} + 32'd4);
      compare_value("obi_be_o", log_be[1], be_lanes[7:4]);
      compare_value("obi_we_o", log_we[1], we);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic idle_after_reset();
    @(negedge clk);
    compare_value("obi_req_o", obi_req, 1'b0);
    compare_value("lsu_rvalid_o", lsu_rvalid, 1'b0);
    compare_value("lsu_busy_o", lsu_busy, 1'b0);
    compare_value("lsu_ready_o", lsu_ready, 1'b1);
  endtask

  task automatic aligned_words();
    for (int k = 0; k < 8; k++) begin
      do_access(1'b1, 2'd2, 32'h40 + 4 * k, $random(seed));
    end
    for (int k = 0; k < 8; k++) begin
      do_access(1'b0, 2'd2, 32'h40 + 4 * k, '0);
    end
  endtask

  // Halfwords at offset 3 also split, which is fine here
  task automatic narrow_loads();
    for (int off = 0; off < 4; off++) begin
      do_access(1'b0, 2'd0, 32'h80 + off, '0);
      do_access(1'b0, 2'd1, 32'ha0 + off, '0);
    end
  endtask

  task automatic crossing_accesses();
    for (int i = 1; i < 4; i++) begin
      do_access(1'b1, 2'd2, 32'h50 + 9 * i, $random(seed));
      do_access(1'b0, 2'd2, 32'h50 + 9 * i, '0);
    end
    do_access(1'b1, 2'd1, 32'h37, $random(seed));
    do_access(1'b0, 2'd1, 32'h37, '0);
    // The second word wraps to the bottom of the memory model
    do_access(1'b1, 2'd2, 32'hfd, $random(seed));
    do_access(1'b0, 2'd2, 32'hfd, '0);
  endtask

  task automatic random_traffic();
    logic        we;
    logic [1:0]  size;
    logic [31:0] addr;
    random_delays = 1'b1;
    for (int n = 0; n < 200; n++) begin
      we   = $random(seed) & 1;
      size = 2'(($random(seed) & 32'h7fff_ffff) % 3);
      addr = $random(seed) & 32'hff;
      do_access(we, size, addr, $random(seed));
    end
    random_delays = 1'b0;
  endtask

  initial begin
    lsu_valid     = 1'b0;
    lsu_we        = 1'b0;
    lsu_size      = 2'd0;
    lsu_addr      = '0;
    lsu_wdata     = '0;
    random_delays = 1'b0;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = fill_byte(a);
    end
    await_reset();
    idle_after_reset();
    aligned_words();
    narrow_loads();
    crossing_accesses();
    random_traffic();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== lsu_top.sv ====
// Load/store unit top level with plain instruction and OBI ports
// A new instruction may enter while earlier transfers still wait on the bus
// lsu_busy_o covers the result cycle, so it drops after lsu_rvalid_o
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Instruction side
  input  logic                   lsu_valid_i,
  output logic                   lsu_ready_o,
  input  logic                   lsu_we_i,
  input  logic [1:0]             lsu_size_i,
  input  logic [`LSU_ADDR_W-1:0] lsu_addr_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  output logic                   lsu_rvalid_o,
  output logic [`LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_busy_o,
  // Bus side
  output logic                   obi_req_o,
  input  logic                   obi_gnt_i,
  output logic [`LSU_ADDR_W-1:0] obi_addr_o,
  output logic                   obi_we_o,
  output logic [3:0]             obi_be_o,
  output logic [`LSU_DATA_W-1:0] obi_wdata_o,
  input  logic                   obi_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] obi_rdata_i
);

  logic split_busy;
  logic buf_full;
  logic obi_pending;

  lsu_xfer_if split_to_buf ();
  lsu_xfer_if buf_to_obi ();

  lsu_split_unit split_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .lsu_valid_i (lsu_valid_i),
    .lsu_ready_o (lsu_ready_o),
    .lsu_we_i    (lsu_we_i),
    .lsu_size_i  (lsu_size_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .busy_o      (split_busy),
    .xfer_o      (split_to_buf.src)
  );

  // Absorbs a withheld grant so the split unit can finish its first part
  lsu_xfer_buffer buf_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .in_i   (split_to_buf.dst),
    .out_o  (buf_to_obi.src),
    .full_o (buf_full)
  );

  lsu_obi_master obi_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .xfer_i       (buf_to_obi.dst),
    .obi_req_o    (obi_req_o),
    .obi_gnt_i    (obi_gnt_i),
    .obi_addr_o   (obi_addr_o),
    .obi_we_o     (obi_we_o),
    .obi_be_o     (obi_be_o),
    .obi_wdata_o  (obi_wdata_o),
    .obi_rvalid_i (obi_rvalid_i),
    .obi_rdata_i  (obi_rdata_i),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .pending_o    (obi_pending)
  );

  assign lsu_busy_o = split_busy || buf_full || obi_pending;

endmodule

// ==== lsu_xfer_buffer.sv ====
// One-entry transfer register between the split unit and the bus master
// It takes a new entry when empty or when the held entry leaves in the same cycle
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_xfer_buffer (
  input  logic    clk,
  input  logic    rst_n,
  lsu_xfer_if.dst in_i,
  lsu_xfer_if.src out_o,
  output logic    full_o
);

  logic                   full_q;
  logic                   push;
  logic                   pop;

  // Held transfer
  logic [`LSU_ADDR_W-3:0] word_addr_q;
  logic                   we_q;
  logic [3:0]             be_q;
  logic [`LSU_DATA_W-1:0] wdata_q;
  logic [1:0]             offset_q;
  logic [1:0]             size_q;
  logic                   split_q;
  logic                   last_q;

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////

  assign pop       = full_q && out_o.ready;
  assign in_i.ready = !full_q || out_o.ready;
  assign push      = in_i.valid && in_i.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (pop) begin
      full_q <= 1'b0;
    end
  end

  // The entry is overwritten in the same cycle it drains
  always_ff @(posedge clk) begin
    if (push) begin
      word_addr_q <= in_i.word_addr;
      we_q        <= in_i.we;
      be_q        <= in_i.be;
      wdata_q     <= in_i.wdata;
      offset_q    <= in_i.offset;
      size_q      <= in_i.size;
      split_q     <= in_i.split;
      last_q      <= in_i.last;
    end
  end

  //////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////

  assign out_o.valid     = full_q;
  assign out_o.word_addr = word_addr_q;
  assign out_o.we        = we_q;
  assign out_o.be        = be_q;
  assign out_o.wdata     = wdata_q;
  assign out_o.offset    = offset_q;
  assign out_o.size      = size_q;
  assign out_o.split     = split_q;
  assign out_o.last      = last_q;
  assign full_o          = full_q;

endmodule

// ==== lsu_xfer_if.sv ====
// One word-aligned transfer between two stages of the load/store unit
// The source holds valid and the payload stable until ready is seen high
`timescale 1ns/1ps
`include "lsu_consts.svh"

interface lsu_xfer_if;

  // Handshake
  logic                   valid;
  logic                   ready;

  // Request payload
  logic [`LSU_ADDR_W-3:0] word_addr;
  logic                   we;
  logic [3:0]             be;
  logic [`LSU_DATA_W-1:0] wdata;

  // Metadata needed later to rebuild the load result
  logic [1:0]             offset;
  logic [1:0]             size;
  logic                   split;
  logic                   last;

  modport src (
    output valid, word_addr, we, be, wdata, offset, size, split, last,
    input  ready
  );

  modport dst (
    input  valid, word_addr, we, be, wdata, offset, size, split, last,
    output ready
  );

endinterface

// ==== project.f ====
+incdir+.
lsu_pkg.sv
lsu_xfer_if.sv
lsu_split_unit.sv
lsu_xfer_buffer.sv
lsu_obi_master.sv
lsu_top.sv
lsu_properties.sv
tb_clock_gen.sv
lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the load/store unit testbench with Verilator and runs it
# The run fails when the log holds the fail message or lacks the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module lsu_tb \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vlsu_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
echo "Run passed"

// ==== tb_clock_gen.sv ====
// Clock and reset source for the load/store unit testbench
// Clock period is 100 ns, reset is held low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release shortly after an edge so no flop sees reset and clock together
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule
